// File: emailbox.f
src/mbox_pkg.sv
src/mbox_write_decode.sv
src/mbox_fifo.sv
src/mbox_read_port.sv
src/emailbox.sv
verif/tb_emailbox.sv

// File: Makefile
# Verilator build and run for the mesh mailbox testbench

TOP      ?= tb_emailbox
FILELIST ?= emailbox.f
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --binary --timing --assert -Wno-fatal -j 0
VERILATOR ?= verilator

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_emailbox.sv
/*
 * Directed testbench for the mesh mailbox.
 * Sends message writes and register reads to emailbox, keeps a reference
 * queue of accepted messages and checks every word read back.
 */
module tb_emailbox;
   import mbox_pkg::*;

   localparam int POLL_LIMIT = 50; // STAT reads before giving up

   logic          rd_clk;
   logic          rst_n;
   logic          emesh_access;
   emesh_packet_t emesh_packet;
   logic          reg_access;
   emesh_packet_t reg_packet;
   logic          mailbox_irq_en;
   logic [31:0]   reg_rdata;
   logic          mailbox_irq;
   logic          mailbox_wait;

   logic [63:0]   exp_q[$];  // Messages the DUT should hold
   logic [31:0]   rng_state; // Xorshift state

   emailbox dut_i
   (
      .rd_clk         (rd_clk),
      .rst_n          (rst_n),
      .emesh_access   (emesh_access),
      .emesh_packet   (emesh_packet),
      .reg_access     (reg_access),
      .reg_packet     (reg_packet),
      .mailbox_irq_en (mailbox_irq_en),
      .reg_rdata      (reg_rdata),
      .mailbox_irq    (mailbox_irq),
      .mailbox_wait   (mailbox_wait)
   );

   always
   begin
      #5 rd_clk = ~rd_clk; // Period 10
   end

   // ############################
   // Helpers
   // ############################
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // This node's address for a register index
   function automatic logic [31:0] mbox_addr(input logic [5:0] idx);
      return {MBOX_ID, EGROUP_MMR, 5'b0_0000, EGROUP_MESH, idx, 2'b00};
   endfunction

   // Expected STAT word for n queued messages
   function automatic logic [31:0] status_word(input int n);
      logic [31:0] w;
      w        = '0;
      w[31:24] = 8'(n);
      w[2]     = (n >= MBOX_PROG_FULL); // prog_full
      w[1]     = (n == MBOX_DEPTH);     // full
      w[0]     = (n != 0);              // not_empty
      return w;
   endfunction

   task automatic random_msg(output logic [63:0] msg);
      rng_state  = xorshift32(rng_state);
      msg[63:32] = rng_state;
      rng_state  = xorshift32(rng_state);
      msg[31:0]  = rng_state;
   endtask

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_value(input string test, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected)
      begin
         stop_with_failure($sformatf("FAIL %s: expected 0x%0h, actual 0x%0h",
                                     test, expected, actual));
      end
   endtask

   // One-cycle mesh strobe
   task automatic send_packet(input logic [63:0] msg, input logic [31:0] dst,
                              input logic wr);
      @(posedge rd_clk);
      #1;
      emesh_access          = 1'b1;
      emesh_packet.srcaddr  = msg[63:32]; // Becomes message hi
      emesh_packet.data     = msg[31:0];  // Becomes message lo
      emesh_packet.dstaddr  = dst;
      emesh_packet.ctrlmode = 5'd0;
      emesh_packet.datamode = 2'b11;
      emesh_packet.write    = wr;
      @(posedge rd_clk);
      #1;
      emesh_access = 1'b0;
   endtask

   // Valid message write, dropped by the model when full
   task automatic send_message(input logic [63:0] msg);
      send_packet(msg, mbox_addr(REG_MAILBOXLO), 1'b1);
      if (exp_q.size() < MBOX_DEPTH)
      begin
         exp_q.push_back(msg);
      end
   endtask

   // Data shows up one cycle after the strobe
   task automatic read_reg(input logic [5:0] idx, output logic [31:0] data);
      @(posedge rd_clk);
      #1;
      reg_access         = 1'b1;
      reg_packet         = '0;
      reg_packet.dstaddr = mbox_addr(idx);
      reg_packet.write   = 1'b0;
      @(posedge rd_clk);
      #1;
      reg_access = 1'b0;
      data       = reg_rdata; // Registered, stable here
   endtask

   task automatic read_hi(input string test);
      logic [31:0] data;
      read_reg(REG_MAILBOXHI, data);
      check_value({test, " hi"}, exp_q[0][63:32], data); // No pop
   endtask

   task automatic read_lo(input string test);
      logic [31:0] data;
      logic [63:0] exp;
      exp = exp_q.pop_front();
      read_reg(REG_MAILBOXLO, data);
      check_value({test, " lo"}, exp[31:0], data);
   endtask

   // HI then LO against the queue head
   task automatic read_message(input string test);
      if (exp_q.size() == 0)
      begin
         stop_with_failure({test, ": reference queue is empty, nothing to read"});
      end
      else
      begin
         read_hi(test);
         read_lo(test);
      end
   endtask

   task automatic check_status(input string test);
      logic [31:0] data;
      read_reg(REG_MAILBOXSTAT, data);
      check_value({test, " stat"}, status_word(exp_q.size()), data);
   endtask

   // Poll STAT until it shows n messages
   task automatic wait_for_status(input string test, input int n);
      logic [31:0] stat;
      int          polls;
      polls = 0;
      read_reg(REG_MAILBOXSTAT, stat);
      while (stat !== status_word(n))
      begin
         polls++;
         if (polls >= POLL_LIMIT)
         begin
            stop_with_failure($sformatf("%s: status never showed %0d messages", test, n));
         end
         else
         begin
            read_reg(REG_MAILBOXSTAT, stat);
         end
      end
   endtask

   // ############################
   // Tests
   // ############################
   task automatic test_reset();
      logic [31:0] data;
      check_value("reset irq", 1'b0, mailbox_irq);
      check_value("reset wait", 1'b0, mailbox_wait);
      check_value("reset rdata", 32'd0, reg_rdata);
      check_status("reset");
      read_reg(REG_MAILBOXLO, data);     // Empty LO read
      check_value("reset empty lo", 32'd0, data);
      check_status("reset after lo");    // Still empty
   endtask

   task automatic test_ordered();
      logic [63:0] msg;
      int          i;
      for (i = 0; i < 3; i++)
      begin
         random_msg(msg);
         send_message(msg);
      end
      wait_for_status("ordered", 3);
      for (i = 0; i < 3; i++)
      begin
         read_message("ordered");
      end
      check_status("ordered end");       // Count back to zero
   endtask

   task automatic test_filtering();
      logic [63:0] msg;
      logic [31:0] good;
      good = mbox_addr(REG_MAILBOXLO);
      random_msg(msg);
      send_packet(msg, good ^ 32'h0010_0000, 1'b1); // Wrong ID
      check_status("filter id");
      send_packet(msg, good ^ 32'h0001_0000, 1'b1); // Wrong MMR group
      check_status("filter mmr");
      send_packet(msg, good ^ 32'h0000_0100, 1'b1); // Wrong mesh group
      check_status("filter mesh");
      send_packet(msg, mbox_addr(REG_MAILBOXHI), 1'b1);
      check_status("filter hi index");
      send_packet(msg, good, 1'b0);                 // Read, not a write
      check_status("filter write bit");
      send_message(msg);                            // Control case
      wait_for_status("filter good", 1);
      read_message("filter good");
   endtask

   task automatic test_fill();
      logic [63:0] msg;
      int          i;
      for (i = 0; i < MBOX_PROG_FULL; i++)
      begin
         random_msg(msg);
         send_message(msg);
      end
      wait_for_status("fill prog_full", MBOX_PROG_FULL);
      check_value("fill wait", 1'b1, mailbox_wait);
      for (i = MBOX_PROG_FULL; i < MBOX_DEPTH; i++)
      begin
         random_msg(msg);
         send_message(msg);
      end
      wait_for_status("fill full", MBOX_DEPTH);
      random_msg(msg);
      send_message(msg);                 // 33rd, must be dropped
      check_status("fill drop");
      for (i = 0; i < MBOX_DEPTH; i++)
      begin
         read_message("fill drain");
      end
      check_status("fill end");
      check_value("fill wait end", 1'b0, mailbox_wait);
   endtask

   task automatic test_irq();
      logic [63:0] msg;
      @(posedge rd_clk);
      #1;
      mailbox_irq_en = 1'b0;
      random_msg(msg);
      send_message(msg);
      random_msg(msg);
      send_message(msg);
      wait_for_status("irq", 2);
      check_value("irq masked", 1'b0, mailbox_irq);
      @(posedge rd_clk);
      #1;
      mailbox_irq_en = 1'b1;
      @(posedge rd_clk);
      #1;
      check_value("irq enabled", 1'b1, mailbox_irq);
      read_message("irq first");
      check_value("irq one left", 1'b1, mailbox_irq);
      read_message("irq last");
      check_value("irq drained", 1'b0, mailbox_irq); // Falls after last pop
   endtask

   task automatic test_random();
      logic [63:0] msg;
      logic [31:0] r;
      int          i;
      for (i = 0; i < 300; i++)
      begin
         rng_state = xorshift32(rng_state);
         r         = rng_state;
         if (exp_q.size() == 0 || (r[2] == 1'b0 && exp_q.size() < MBOX_DEPTH - 2))
         begin
            random_msg(msg);
            send_message(msg);
         end
         else
         begin
            case (r[1:0])
               2'd0:    read_hi("random");
               2'd1:    read_lo("random");
               2'd2:    check_status("random");
               default: read_message("random");
            endcase
         end
      end
      while (exp_q.size() != 0)
      begin
         read_message("random drain");
      end
      check_status("random end");
   endtask

   // ############################
   // Main sequence
   // ############################
   initial
   begin
      rd_clk         = 1'b0;
      rst_n          = 1'b0;
      emesh_access   = 1'b0;
      emesh_packet   = '0;
      reg_access     = 1'b0;
      reg_packet     = '0;
      mailbox_irq_en = 1'b1; // So a low irq after reset means something
      rng_state      = 32'hf1a2_9a74;
      repeat (5) @(posedge rd_clk);
      #1;
      rst_n = 1'b1;

      test_reset();
      test_ordered();
      test_filtering();
      test_fill();
      test_irq();
      test_random();

      $display("TB PASSED");
      $finish;
   end

endmodule

// File: src/emailbox.sv
/*
 * Mesh endpoint mailbox, top level.
 * Message writes from the mesh fill a 64-bit FIFO; the register port
 * reads it back as HI, LO (popping) and STAT words. Drives a level
 * interrupt and an advisory push-back level.
 */
module emailbox
(
   input  logic                    rd_clk,
   input  logic                    rst_n,
   input  logic                    emesh_access,   // Message write strobe
   input  mbox_pkg::emesh_packet_t emesh_packet,
   input  logic                    reg_access,     // Register read strobe
   input  mbox_pkg::emesh_packet_t reg_packet,
   input  logic                    mailbox_irq_en,
   output logic [31:0]             reg_rdata,
   output logic                    mailbox_irq,    // Level interrupt
   output logic                    mailbox_wait    // Push-back to senders
);
   import mbox_pkg::*;

   logic               push;
   mbox_payload_u      push_msg;
   logic               pop;
   mbox_payload_u      head;
   logic [MBOX_CW-1:0] count;
   logic               empty;
   logic               full;
   logic               prog_full;
   mbox_status_t       status;

   // ############################
   // Write path
   // ############################
   mbox_write_decode write_decode_i
   (
      .emesh_access (emesh_access),
      .emesh_packet (emesh_packet),
      .full         (full),
      .push         (push),
      .push_msg     (push_msg)
   );

   // ############################
   // Message FIFO
   // ############################
   mbox_fifo fifo_i
   (
      .rd_clk    (rd_clk),
      .rst_n     (rst_n),
      .push      (push),
      .push_msg  (push_msg),
      .pop       (pop),
      .head      (head),
      .count     (count),
      .empty     (empty),
      .full      (full),
      .prog_full (prog_full)
   );

   // ############################
   // Read path
   // ############################
   mbox_read_port read_port_i
   (
      .rd_clk     (rd_clk),
      .rst_n      (rst_n),
      .reg_access (reg_access),
      .reg_packet (reg_packet),
      .head       (head),
      .empty      (empty),
      .status     (status),
      .pop        (pop),
      .reg_rdata  (reg_rdata)
   );

   // Status word for STAT reads
   assign status = '{count:     8'(count),
                     reserved:  '0,
                     prog_full: prog_full,
                     full:      full,
                     not_empty: ~empty};

   // Level interrupt, held while anything is queued
   assign mailbox_irq  = mailbox_irq_en & (~empty | prog_full | full);
   assign mailbox_wait = prog_full; // Advisory only

endmodule

// File: src/mbox_read_port.sv
/*
 * Register read port of the mailbox.
 * Decodes reads by register index only, pops the FIFO on a MAILBOXLO
 * read and returns the selected word on reg_rdata one cycle later.
 * reg_rdata holds its value until the next read.
 */
module mbox_read_port
(
   input  logic                    rd_clk,
   input  logic                    rst_n,
   input  logic                    reg_access,
   input  mbox_pkg::emesh_packet_t reg_packet,
   input  mbox_pkg::mbox_payload_u head,
   input  logic                    empty,
   input  mbox_pkg::mbox_status_t  status,
   output logic                    pop,
   output logic [31:0]             reg_rdata
);
   import mbox_pkg::*;

   logic        reg_read;  // Read access this cycle
   logic [5:0]  reg_idx;   // Register index from addr [7:2]
   logic        sel_lo;    // Low word only when a message is there
   logic        sel_hi;
   logic        sel_stat;
   logic [31:0] rdata_nxt; // Word captured at the edge

   // ############################
   // Decode
   // ############################
   assign reg_read = reg_access & ~reg_packet.write;
   assign reg_idx  = reg_packet.dstaddr[7:2];

   assign sel_lo   = reg_read & (reg_idx == REG_MAILBOXLO) & ~empty;
   assign sel_hi   = reg_read & (reg_idx == REG_MAILBOXHI);
   assign sel_stat = reg_read & (reg_idx == REG_MAILBOXSTAT);

   assign pop = sel_lo; // LO read consumes the head

   // AND-OR mux gives zero with no select
   assign rdata_nxt = ({32{sel_lo}}   & head.msg.lo) |
                      ({32{sel_hi}}   & head.msg.hi) |
                      ({32{sel_stat}} & 32'(status));

   // ############################
   // Read data register
   // ############################
   // Head and status taken before the pop lands
   always_ff @(posedge rd_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         reg_rdata <= '0;
      end
      else if (reg_read)
      begin
         reg_rdata <= rdata_nxt; // Unknown index or empty LO reads zero
      end
   end

endmodule

// File: src/mbox_fifo.sv
/*
 * Single-clock message FIFO for the mailbox.
 * Show-ahead: head always presents the oldest message, a pop just
 * advances to the next one. Count, empty, full and prog_full follow
 * each push or pop at the clock edge that takes it.
 */
module mbox_fifo
(
   input  logic                          rd_clk,
   input  logic                          rst_n,
   input  logic                          push,
   input  mbox_pkg::mbox_payload_u       push_msg,
   input  logic                          pop,
   output mbox_pkg::mbox_payload_u       head,
   output logic [mbox_pkg::MBOX_CW-1:0]  count,
   output logic                          empty,
   output logic                          full,
   output logic                          prog_full
);
   import mbox_pkg::*;

   localparam logic [MBOX_CW-1:0] DEPTH_C = MBOX_CW'(MBOX_DEPTH);
   localparam logic [MBOX_CW-1:0] PFULL_C = MBOX_CW'(MBOX_PROG_FULL);

   mbox_payload_u      mem [MBOX_DEPTH]; // Message storage
   logic [MBOX_AW-1:0] wr_ptr;           // Next slot to fill
   logic [MBOX_AW-1:0] rd_ptr;           // Oldest message

   // ############################
   // Storage
   // ############################
   always_ff @(posedge rd_clk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= push_msg;
      end
   end

   assign head = mem[rd_ptr]; // Show-ahead read

   // ############################
   // Pointers
   // ############################
   // Depth is a power of two, pointers wrap on their own
   always_ff @(posedge rd_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // ############################
   // Occupancy
   // ############################
   always_ff @(posedge rd_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         count <= '0;
      end
      else
      begin
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // Idle or push with pop
         endcase
      end
   end

   // Flags straight from the counter
   assign empty     = (count == '0);
   assign full      = (count == DEPTH_C);
   assign prog_full = (count >= PFULL_C); // Push-back threshold

   // ############################
   // Checks
   // ############################
   a_no_push_full : assert property (
      @(posedge rd_clk) disable iff (!rst_n)
      push |-> !full
   ) else $error("mbox_fifo: push into full FIFO");

   a_no_pop_empty : assert property (
      @(posedge rd_clk) disable iff (!rst_n)
      pop |-> !empty
   ) else $error("mbox_fifo: pop from empty FIFO");

   // Counter stays within the storage
   a_count_range : assert property (
      @(posedge rd_clk) disable iff (!rst_n)
      count <= DEPTH_C
   ) else $error("mbox_fifo: count above depth");

endmodule

// File: src/mbox_write_decode.sv
/*
 * Write-side address filter for incoming mesh messages.
 * A packet is pushed into the mailbox FIFO only when it is a write aimed
 * at this node's MAILBOXLO register and the FIFO has room.
 */
module mbox_write_decode
(
   input  logic                    emesh_access,
   input  mbox_pkg::emesh_packet_t emesh_packet,
   input  logic                    full,
   output logic                    push,
   output mbox_pkg::mbox_payload_u push_msg
);
   import mbox_pkg::*;

   logic [31:0] dst;       // Destination address
   logic        id_hit;    // Node ID match
   logic        group_hit; // MMR and mesh group match
   logic        reg_hit;   // Register index is MAILBOXLO
   logic        wr_req;    // Valid message write

   assign dst = emesh_packet.dstaddr;

   // ############################
   // Address match
   // ############################
   assign id_hit    = (dst[31:20] == MBOX_ID);
   assign group_hit = (dst[19:16] == EGROUP_MMR) &&
                      (dst[10:8]  == EGROUP_MESH);
   assign reg_hit   = (dst[7:2] == REG_MAILBOXLO); // HI and STAT not writable

   // Reads on the mesh port are ignored
   assign wr_req = emesh_access & emesh_packet.write;

   // Full FIFO drops the write silently
   assign push = wr_req & id_hit & group_hit & reg_hit & ~full;

   // Bus fields land in the message words
   assign push_msg.bus = '{srcaddr: emesh_packet.srcaddr,
                           data:    emesh_packet.data};

endmodule

// File: src/mbox_pkg.sv
/*
 * Shared types and constants for the mesh mailbox.
 * Holds the mesh packet layout, the payload union, the status word,
 * the address codes of this node and the FIFO sizing.
 */
package mbox_pkg;

   // ############################
   // Node address decode
   // ############################
   localparam logic [11:0] MBOX_ID     = 12'h808; // Addr [31:20], this node
   localparam logic [3:0]  EGROUP_MMR  = 4'hf;    // Addr [19:16], MMR space
   localparam logic [2:0]  EGROUP_MESH = 3'h1;    // Addr [10:8], mesh block

   // Register indices, compared with addr [7:2]
   localparam logic [5:0]  REG_MAILBOXLO   = 6'h09; // Low word, pops on read
   localparam logic [5:0]  REG_MAILBOXHI   = 6'h0a; // High word, no pop
   localparam logic [5:0]  REG_MAILBOXSTAT = 6'h0b; // Status word

   // ############################
   // FIFO sizing
   // ############################
   localparam int MBOX_DEPTH     = 32;               // Entries, power of two
   localparam int MBOX_AW        = $clog2(MBOX_DEPTH); // Pointer width
   localparam int MBOX_CW        = MBOX_AW + 1;      // Count 0..DEPTH
   localparam int MBOX_PROG_FULL = 28;               // Push-back level

   // ############################
   // Mesh packet, 104 bits
   // ############################
   typedef struct packed {
      logic [31:0] srcaddr;  // Upper message word on writes
      logic [31:0] data;     // Lower message word on writes
      logic [31:0] dstaddr;
      logic [4:0]  ctrlmode;
      logic [1:0]  datamode;
      logic        write;    // Set for writes, clear for reads
   } emesh_packet_t;

   // Payload as it sits on the bus
   typedef struct packed {
      logic [31:0] srcaddr;
      logic [31:0] data;
   } mbox_bus_t;

   // Same payload as one mailbox message
   typedef struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
   } mbox_msg_t;

   // 64-bit word seen both ways
   typedef union packed {
      mbox_bus_t bus;
      mbox_msg_t msg;
   } mbox_payload_u;

   // ############################
   // Status register layout
   // ############################
   typedef struct packed {
      logic [7:0]  count;     // Messages held
      logic [20:0] reserved;  // Reads as zero
      logic        prog_full;
      logic        full;
      logic        not_empty;
   } mbox_status_t;

endpackage
